// File: common/cachePkg.sv
// cache geometry constants, controller state codes, word, block and address types
`default_nettype none

package cachePkg;

  //////////////////////////////////////////////////
  // geometry
  //////////////////////////////////////////////////

  localparam int wordBits     = 32;
  localparam int wordSelBits  = 3;                        // word within a block
  localparam int wordsPerBlock = 1 << wordSelBits;
  localparam int indexBits    = 4;                        // cache line index
  localparam int cacheLines   = 1 << indexBits;
  localparam int tagBits      = 2;
  localparam int blockNumBits = tagBits + indexBits;      // tag and index together
  localparam int memBlocks    = 1 << blockNumBits;
  localparam int addrBits     = blockNumBits + wordSelBits;

  // backing store contents, one block per line
  localparam string memInitFile = "memory/memInit.hex";

  // controller states
  localparam logic ctrlIdle = 1'b0;
  localparam logic ctrlFill = 1'b1; // waiting on a block from memory

  //////////////////////////////////////////////////
  // types
  //////////////////////////////////////////////////

  typedef logic [wordBits-1:0] word_t;

  // word 0 sits in the low bits
  typedef word_t [wordsPerBlock-1:0] block_t;

  // word address, seen flat or split into its fields
  typedef union packed {
    logic [addrBits-1:0] flat;
    struct packed {
      logic [tagBits-1:0]     tag;
      logic [indexBits-1:0]   index;
      logic [wordSelBits-1:0] wordSel;
    } part;
  } cacheAddr_t;

endpackage

`default_nettype wire

// File: cache/tagStore.sv
// tag store: valid bit and tag per line, hit compare, install on fill
`timescale 1ns/100ps
`default_nettype none

module tagStore (
  input  logic                           clk,
  input  logic                           reset,
  input  logic [cachePkg::indexBits-1:0] index,
  input  logic [cachePkg::tagBits-1:0]   tag,
  input  logic                           fill,
  output logic                           lineHit
);
  import cachePkg::*;

  logic [cacheLines-1:0] valid;
  logic [tagBits-1:0]    tags [cacheLines];

  // present and same tag
  assign lineHit = valid[index] && (tags[index] == tag);

  //////////////////////////////////////////////////
  // valid bits
  //////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (reset) begin
      valid <= '0;       // all lines empty
    end else if (fill) begin
      valid[index] <= 1'b1;
    end
  end

  //////////////////////////////////////////////////
  // tags
  //////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (fill) begin
      tags[index] <= tag;
    end
  end

endmodule

`default_nettype wire

// File: cache/lineStore.sv
// cache data lines: word-select read, single word write, whole line fill
`timescale 1ns/100ps
`default_nettype none

module lineStore (
  input  logic                             clk,
  input  logic [cachePkg::indexBits-1:0]   index,
  input  logic [cachePkg::wordSelBits-1:0] wordSel,
  input  logic                             fill,
  input  cachePkg::block_t                 fillBlock,
  input  logic                             wordWrite,
  input  cachePkg::word_t                  writeData,
  output cachePkg::word_t                  lineWord
);
  import cachePkg::*;

  block_t lines [cacheLines];

  // combinational word read
  assign lineWord = lines[index][wordSel];

  //////////////////////////////////////////////////
  // line updates
  //////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (fill) begin
      lines[index] <= fillBlock;            // miss refill
    end else if (wordWrite) begin
      lines[index][wordSel] <= writeData;   // write hit
    end
  end

endmodule

`default_nettype wire

// File: cache/cacheCtrl.sv
// cache controller: request accept, miss fill sequence, write-through, response registers
`timescale 1ns/100ps
`default_nettype none

module cacheCtrl (
  input  logic                              clk,
  input  logic                              reset,
  input  logic                              req,
  input  logic                              write,
  input  cachePkg::cacheAddr_t              addr,
  input  cachePkg::word_t                   writeData,
  input  logic                              lineHit,
  input  cachePkg::word_t                   lineWord,
  input  cachePkg::block_t                  memBlock,
  output logic [cachePkg::indexBits-1:0]    index,
  output logic [cachePkg::tagBits-1:0]      tag,
  output logic [cachePkg::wordSelBits-1:0]  wordSel,
  output logic                              fill,
  output logic                              wordWrite,
  output cachePkg::word_t                   cacheWriteData,
  output logic                              memRead,
  output logic [cachePkg::blockNumBits-1:0] blockNum,
  output logic                              memWrite,
  output cachePkg::cacheAddr_t              memAddr,
  output cachePkg::word_t                   memWriteData,
  output logic                              busy,
  output logic                              done,
  output logic                              hit,
  output cachePkg::word_t                   readData
);
  import cachePkg::*;

  logic       state;
  logic       accept;
  cacheAddr_t liveAddr;
  cacheAddr_t addrQ;    // accepted request
  word_t      dataQ;
  logic       rspValid; // hit read or write answers next edge
  logic       rspRead;
  logic       rspHit;
  word_t      rspWord;

  assign accept   = req && !busy;
  // held address while a request is in flight, else the one on the port
  assign liveAddr = busy ? addrQ : addr;

  assign index   = liveAddr.part.index;
  assign tag     = liveAddr.part.tag;
  assign wordSel = liveAddr.part.wordSel;

  assign blockNum       = {addrQ.part.tag, addrQ.part.index};
  assign memAddr        = addrQ;
  assign memWriteData   = dataQ;
  assign cacheWriteData = dataQ; // same word goes to both sides

  //////////////////////////////////////////////////
  // sequencing
  //////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (reset) begin
      state     <= ctrlIdle;
      busy      <= 1'b0;
      done      <= 1'b0;
      hit       <= 1'b0;
      fill      <= 1'b0;
      wordWrite <= 1'b0;
      memRead   <= 1'b0;
      memWrite  <= 1'b0;
      rspValid  <= 1'b0;
    end else begin
      done      <= 1'b0;
      fill      <= 1'b0;
      wordWrite <= 1'b0;
      memRead   <= 1'b0;
      memWrite  <= 1'b0;
      rspValid  <= 1'b0;
      if (rspValid) begin
        done <= 1'b1;
        hit  <= rspHit;
        busy <= 1'b0;        // frees the port after a write
      end
      if (state == ctrlFill) begin
        if (memRead) begin
          fill <= 1'b1;      // block lands this edge, install next
        end else if (fill) begin
          state <= ctrlIdle;
          busy  <= 1'b0;
          done  <= 1'b1;
          hit   <= rspHit;
        end
      end else if (accept) begin
        if (write) begin
          memWrite  <= 1'b1;
          wordWrite <= lineHit; // no allocate on a write miss
          busy      <= 1'b1;
          rspValid  <= 1'b1;
        end else if (lineHit) begin
          rspValid <= 1'b1;
        end else begin
          memRead <= 1'b1;
          busy    <= 1'b1;
          state   <= ctrlFill;
        end
      end
    end
  end

  //////////////////////////////////////////////////
  // request and response payload
  //////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (accept) begin
      addrQ   <= addr;
      dataQ   <= writeData;
      rspRead <= !write;
      rspHit  <= lineHit;  // hit as seen at request time
      rspWord <= lineWord;
    end
    if (rspValid && rspRead) begin
      readData <= rspWord;
    end
    if (state == ctrlFill && fill) begin
      readData <= memBlock[addrQ.part.wordSel]; // word out of the fresh block
    end
  end

endmodule

`default_nettype wire

// File: memory/blockMemory.sv
// backing memory: block-wide registered read, word write, preloaded from hex file
`timescale 1ns/100ps
`default_nettype none

module blockMemory (
  input  logic                              clk,
  input  logic                              memRead,
  input  logic [cachePkg::blockNumBits-1:0] blockNum,
  output cachePkg::block_t                  memBlock,
  input  logic                              memWrite,
  input  cachePkg::cacheAddr_t              memAddr,
  input  cachePkg::word_t                   memWriteData
);
  import cachePkg::*;

  block_t mem [memBlocks];

  // contents at time zero
  initial begin
    $readmemh(memInitFile, mem);
  end

  //////////////////////////////////////////////////
  // access
  //////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (memRead) begin
      memBlock <= mem[blockNum]; // ready one cycle later
    end
    if (memWrite) begin
      mem[{memAddr.part.tag, memAddr.part.index}][memAddr.part.wordSel] <= memWriteData;
    end
  end

endmodule

`default_nettype wire

// File: src/cacheTop.sv
// top level of the write-through data cache with its backing memory
`timescale 1ns/100ps
`default_nettype none

module cacheTop (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 req,
  input  logic                 write,
  input  cachePkg::cacheAddr_t addr,
  input  cachePkg::word_t      writeData,
  output logic                 busy,
  output logic                 done,
  output logic                 hit,
  output cachePkg::word_t      readData
);
  import cachePkg::*;

  // lookup path
  logic [indexBits-1:0]    index;
  logic [tagBits-1:0]      tag;
  logic [wordSelBits-1:0]  wordSel;
  logic                    lineHit;
  word_t                   lineWord;

  // store updates
  logic                    fill;
  logic                    wordWrite;
  word_t                   cacheWriteData;

  // memory side
  logic                    memRead;
  logic [blockNumBits-1:0] blockNum;
  block_t                  memBlock;
  logic                    memWrite;
  cacheAddr_t              memAddr;
  word_t                   memWriteData;

  cacheCtrl cacheCtrl_i (
    .clk            (clk),
    .reset          (reset),
    .req            (req),
    .write          (write),
    .addr           (addr),
    .writeData      (writeData),
    .lineHit        (lineHit),
    .lineWord       (lineWord),
    .memBlock       (memBlock),
    .index          (index),
    .tag            (tag),
    .wordSel        (wordSel),
    .fill           (fill),
    .wordWrite      (wordWrite),
    .cacheWriteData (cacheWriteData),
    .memRead        (memRead),
    .blockNum       (blockNum),
    .memWrite       (memWrite),
    .memAddr        (memAddr),
    .memWriteData   (memWriteData),
    .busy           (busy),
    .done           (done),
    .hit            (hit),
    .readData       (readData)
  );

  tagStore tagStore_i (
    .clk     (clk),
    .reset   (reset),
    .index   (index),
    .tag     (tag),
    .fill    (fill),
    .lineHit (lineHit)
  );

  lineStore lineStore_i (
    .clk       (clk),
    .index     (index),
    .wordSel   (wordSel),
    .fill      (fill),
    .fillBlock (memBlock),   // fills straight from the memory read register
    .wordWrite (wordWrite),
    .writeData (cacheWriteData),
    .lineWord  (lineWord)
  );

  blockMemory blockMemory_i (
    .clk          (clk),
    .memRead      (memRead),
    .blockNum     (blockNum),
    .memBlock     (memBlock),
    .memWrite     (memWrite),
    .memAddr      (memAddr),
    .memWriteData (memWriteData)
  );

endmodule

`default_nettype wire

// File: test/cacheCheck.svh
// reference model of memory and cache state, error counters and typed compare tasks
`ifndef CACHE_CHECK_SVH
`define CACHE_CHECK_SVH

  word_t                 modelMem [memBlocks * wordsPerBlock]; // flat array by word address
  logic [cacheLines-1:0] modelValid;
  logic [tagBits-1:0]    modelTag [cacheLines];
  int                    dataErrors = 0;
  int                    hitErrors  = 0;
  int                    busyErrors = 0;
  int                    doneErrors = 0;

  //////////////////////////////////////////////////
  // model state
  //////////////////////////////////////////////////

  task automatic loadModel();
    block_t blocks [memBlocks];
    $readmemh(memInitFile, blocks);
    for (int b = 0; b < memBlocks; b++) begin
      for (int w = 0; w < wordsPerBlock; w++) begin
        modelMem[b * wordsPerBlock + w] = blocks[b][w]; // word 0 in the low bits
      end
    end
  endtask

  task automatic clearModelCache();
    modelValid = '0;
  endtask

  // line present with a matching tag
  function automatic logic predictHit(input cacheAddr_t a);
    return modelValid[a.part.index] && (modelTag[a.part.index] == a.part.tag);
  endfunction

  // a read miss brings the block in
  task automatic modelRead(input cacheAddr_t a, output word_t data);
    modelValid[a.part.index] = 1'b1;
    modelTag[a.part.index]   = a.part.tag;
    data = modelMem[a.flat];
  endtask

  task automatic modelWrite(input cacheAddr_t a, input word_t data);
    modelMem[a.flat] = data;   // write-through with no allocate
  endtask

  //////////////////////////////////////////////////
  // compares
  //////////////////////////////////////////////////

  task automatic checkWord(input cachePkg::word_t actual, input cachePkg::word_t expected,
                           input cacheAddr_t a);
    if (actual !== expected) begin
      dataErrors++;
      $display("[ERROR] %0t: readData %h at address %h, expected %h",
               $time, actual, a.flat, expected);
    end
  endtask

  task automatic checkHit(input logic actual, input logic expected, input cacheAddr_t a);
    if (actual !== expected) begin
      hitErrors++;
      $display("[ERROR] %0t: hit %b at address %h, expected %b",
               $time, actual, a.flat, expected);
    end
  endtask

  task automatic checkBusy(input logic actual, input logic expected, input cacheAddr_t a);
    if (actual !== expected) begin
      busyErrors++;
      $display("[ERROR] %0t: busy %b at address %h, expected %b",
               $time, actual, a.flat, expected);
    end
  endtask

`endif

// File: test/cacheTb.sv
// data cache testbench with clock, reset, watchdog, directed and random accesses
`timescale 1ns/100ps
`default_nettype none

module cacheTb;
  import cachePkg::*;

  localparam int          clkPeriod   = 20;
  localparam int          resetCycles = 16;
  localparam int          randomOps   = 400;
  localparam int          directedOps = 24;  // upper bound of the directed accesses
  localparam int unsigned seed        = 32'hb44e6e63;
  localparam longint      watchdogTime = longint'(randomOps + directedOps) * 3 * clkPeriod * 2;
  localparam logic [11:0] hotIndices  = {4'd12, 4'd7, 4'd3}; // lines hit by random traffic

  logic       clk;
  logic       reset;
  logic       req;
  logic       write;
  cacheAddr_t addr;
  word_t      writeData;
  logic       busy;
  logic       done;
  logic       hit;
  word_t      readData;

  `include "cacheCheck.svh"

  cacheTop cacheTop_i (
    .clk       (clk),
    .reset     (reset),
    .req       (req),
    .write     (write),
    .addr      (addr),
    .writeData (writeData),
    .busy      (busy),
    .done      (done),
    .hit       (hit),
    .readData  (readData)
  );

  initial begin
    clk = 1'b0;
    forever #(clkPeriod / 2) clk = ~clk;
  end

  initial begin
    #(watchdogTime);
    $display("watchdog expired before the tests finished");
    $display("SOME TESTS FAILED");
    $finish;
  end

  //////////////////////////////////////////////////
  // access tasks
  //////////////////////////////////////////////////

  task automatic applyReset();
    @(posedge clk);
    reset <= 1'b1;
    repeat (resetCycles) @(posedge clk);
    reset <= 1'b0;
    @(negedge clk);
    clearModelCache();
  endtask

  // one request, then wait for done and compare
  task automatic access(input logic isWrite, input logic [addrBits-1:0] flatAddr,
                        input word_t data);
    cacheAddr_t a;
    logic       expHit;
    word_t      expWord;
    logic       seen;
    int         waited;
    int         expLatency;
    a.flat  = flatAddr;
    expHit  = predictHit(a);  // state before this access
    expWord = '0;
    expLatency = (isWrite || expHit) ? 1 : 2; // only a read miss fetches a block
    if (isWrite) begin
      modelWrite(a, data);
    end else begin
      modelRead(a, expWord);
    end
    while (busy) @(negedge clk);
    @(posedge clk);
    req       <= 1'b1;
    write     <= isWrite;
    addr      <= a;
    writeData <= data;
    @(posedge clk);
    req   <= 1'b0;
    write <= 1'b0;
    seen   = 1'b0;
    waited = 0;
    while (!seen && waited < 3) begin
      @(negedge clk);
      waited = waited + 1;
      seen   = done;
      if (waited == 1) begin
        checkBusy(busy, isWrite || !expHit, a); // a read hit never holds the port
      end
    end
    if (!seen) begin
      doneErrors++;
      $display("no done within three cycles of the request to address %h", a.flat);
    end else begin
      if (waited - 1 != expLatency) begin
        doneErrors++;
        $display("done came %0d cycles after the request to address %h instead of %0d",
                 waited - 1, a.flat, expLatency);
      end
      checkBusy(busy, 1'b0, a);
      checkHit(hit, expHit, a);
      if (!isWrite) begin
        checkWord(readData, expWord, a);
      end
    end
  endtask

  task automatic readAt(input logic [addrBits-1:0] flatAddr);
    access(1'b0, flatAddr, '0);
  endtask

  task automatic writeAt(input logic [addrBits-1:0] flatAddr, input word_t data);
    access(1'b1, flatAddr, data);
  endtask

  //////////////////////////////////////////////////
  // test sequence
  //////////////////////////////////////////////////

  initial begin
    int unsigned         rnd;
    int unsigned         pick;
    logic [addrBits-1:0] ra;
    word_t               d1;
    word_t               d2;
    rnd       = $urandom(seed);
    reset     = 1'b1;
    req       = 1'b0;
    write     = 1'b0;
    addr      = '0;
    writeData = '0;
    loadModel();
    applyReset();

    // cold reads all miss
    readAt(9'h000);
    readAt(9'h0a5);
    readAt(9'h1ff);
    // same block, then the same word again
    readAt(9'h001);
    readAt(9'h007);
    readAt(9'h000);
    readAt(9'h0a5);
    // index 5 under tags 0 and 2
    repeat (3) begin
      readAt(9'h028);
      readAt(9'h128);
    end
    // write hit, read back from the line
    d1 = $urandom;
    writeAt(9'h001, d1);
    readAt(9'h001);
    // write miss allocates nothing
    d2 = $urandom;
    writeAt(9'h1c2, d2);
    readAt(9'h1c2);
    readAt(9'h1c2);
    // valid bits go, memory keeps the writes
    applyReset();
    readAt(9'h001);
    readAt(9'h1c2);

    for (int i = 0; i < randomOps; i++) begin
      rnd  = $urandom;
      pick = rnd[31:24] % 3;
      ra   = {rnd[tagBits-1:0], hotIndices[pick * indexBits +: indexBits],
              rnd[8 +: wordSelBits]};
      if (rnd[20:18] < 3'd3) begin
        writeAt(ra, $urandom);
      end else begin
        readAt(ra);
      end
    end

    $display("errors: data %0d, hit %0d, busy %0d, done %0d",
             dataErrors, hitErrors, busyErrors, doneErrors);
    if (dataErrors + hitErrors + busyErrors + doneErrors == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: memory/memInit.hex
// one 256-bit block per line, block 0 first; word 7 leftmost, word 0 rightmost
// the word at word address a reads D, a, 5, a with a as three hex digits
D0075007D0065006D0055005D0045004D0035003D0025002D0015001D0005000
D00F500FD00E500ED00D500DD00C500CD00B500BD00A500AD0095009D0085008
D0175017D0165016D0155015D0145014D0135013D0125012D0115011D0105010
D01F501FD01E501ED01D501DD01C501CD01B501BD01A501AD0195019D0185018
D0275027D0265026D0255025D0245024D0235023D0225022D0215021D0205020
D02F502FD02E502ED02D502DD02C502CD02B502BD02A502AD0295029D0285028
D0375037D0365036D0355035D0345034D0335033D0325032D0315031D0305030
D03F503FD03E503ED03D503DD03C503CD03B503BD03A503AD0395039D0385038
D0475047D0465046D0455045D0445044D0435043D0425042D0415041D0405040
D04F504FD04E504ED04D504DD04C504CD04B504BD04A504AD0495049D0485048
D0575057D0565056D0555055D0545054D0535053D0525052D0515051D0505050
D05F505FD05E505ED05D505DD05C505CD05B505BD05A505AD0595059D0585058
D0675067D0665066D0655065D0645064D0635063D0625062D0615061D0605060
D06F506FD06E506ED06D506DD06C506CD06B506BD06A506AD0695069D0685068
D0775077D0765076D0755075D0745074D0735073D0725072D0715071D0705070
D07F507FD07E507ED07D507DD07C507CD07B507BD07A507AD0795079D0785078
D0875087D0865086D0855085D0845084D0835083D0825082D0815081D0805080
D08F508FD08E508ED08D508DD08C508CD08B508BD08A508AD0895089D0885088
D0975097D0965096D0955095D0945094D0935093D0925092D0915091D0905090
D09F509FD09E509ED09D509DD09C509CD09B509BD09A509AD0995099D0985098
D0A750A7D0A650A6D0A550A5D0A450A4D0A350A3D0A250A2D0A150A1D0A050A0
D0AF50AFD0AE50AED0AD50ADD0AC50ACD0AB50ABD0AA50AAD0A950A9D0A850A8
D0B750B7D0B650B6D0B550B5D0B450B4D0B350B3D0B250B2D0B150B1D0B050B0
D0BF50BFD0BE50BED0BD50BDD0BC50BCD0BB50BBD0BA50BAD0B950B9D0B850B8
D0C750C7D0C650C6D0C550C5D0C450C4D0C350C3D0C250C2D0C150C1D0C050C0
D0CF50CFD0CE50CED0CD50CDD0CC50CCD0CB50CBD0CA50CAD0C950C9D0C850C8
D0D750D7D0D650D6D0D550D5D0D450D4D0D350D3D0D250D2D0D150D1D0D050D0
D0DF50DFD0DE50DED0DD50DDD0DC50DCD0DB50DBD0DA50DAD0D950D9D0D850D8
D0E750E7D0E650E6D0E550E5D0E450E4D0E350E3D0E250E2D0E150E1D0E050E0
D0EF50EFD0EE50EED0ED50EDD0EC50ECD0EB50EBD0EA50EAD0E950E9D0E850E8
D0F750F7D0F650F6D0F550F5D0F450F4D0F350F3D0F250F2D0F150F1D0F050F0
D0FF50FFD0FE50FED0FD50FDD0FC50FCD0FB50FBD0FA50FAD0F950F9D0F850F8
D1075107D1065106D1055105D1045104D1035103D1025102D1015101D1005100
D10F510FD10E510ED10D510DD10C510CD10B510BD10A510AD1095109D1085108
D1175117D1165116D1155115D1145114D1135113D1125112D1115111D1105110
D11F511FD11E511ED11D511DD11C511CD11B511BD11A511AD1195119D1185118
D1275127D1265126D1255125D1245124D1235123D1225122D1215121D1205120
D12F512FD12E512ED12D512DD12C512CD12B512BD12A512AD1295129D1285128
D1375137D1365136D1355135D1345134D1335133D1325132D1315131D1305130
D13F513FD13E513ED13D513DD13C513CD13B513BD13A513AD1395139D1385138
D1475147D1465146D1455145D1445144D1435143D1425142D1415141D1405140
D14F514FD14E514ED14D514DD14C514CD14B514BD14A514AD1495149D1485148
D1575157D1565156D1555155D1545154D1535153D1525152D1515151D1505150
D15F515FD15E515ED15D515DD15C515CD15B515BD15A515AD1595159D1585158
D1675167D1665166D1655165D1645164D1635163D1625162D1615161D1605160
D16F516FD16E516ED16D516DD16C516CD16B516BD16A516AD1695169D1685168
D1775177D1765176D1755175D1745174D1735173D1725172D1715171D1705170
D17F517FD17E517ED17D517DD17C517CD17B517BD17A517AD1795179D1785178
D1875187D1865186D1855185D1845184D1835183D1825182D1815181D1805180
D18F518FD18E518ED18D518DD18C518CD18B518BD18A518AD1895189D1885188
D1975197D1965196D1955195D1945194D1935193D1925192D1915191D1905190
D19F519FD19E519ED19D519DD19C519CD19B519BD19A519AD1995199D1985198
D1A751A7D1A651A6D1A551A5D1A451A4D1A351A3D1A251A2D1A151A1D1A051A0
D1AF51AFD1AE51AED1AD51ADD1AC51ACD1AB51ABD1AA51AAD1A951A9D1A851A8
D1B751B7D1B651B6D1B551B5D1B451B4D1B351B3D1B251B2D1B151B1D1B051B0
D1BF51BFD1BE51BED1BD51BDD1BC51BCD1BB51BBD1BA51BAD1B951B9D1B851B8
D1C751C7D1C651C6D1C551C5D1C451C4D1C351C3D1C251C2D1C151C1D1C051C0
D1CF51CFD1CE51CED1CD51CDD1CC51CCD1CB51CBD1CA51CAD1C951C9D1C851C8
D1D751D7D1D651D6D1D551D5D1D451D4D1D351D3D1D251D2D1D151D1D1D051D0
D1DF51DFD1DE51DED1DD51DDD1DC51DCD1DB51DBD1DA51DAD1D951D9D1D851D8
D1E751E7D1E651E6D1E551E5D1E451E4D1E351E3D1E251E2D1E151E1D1E051E0
D1EF51EFD1EE51EED1ED51EDD1EC51ECD1EB51EBD1EA51EAD1E951E9D1E851E8
D1F751F7D1F651F6D1F551F5D1F451F4D1F351F3D1F251F2D1F151F1D1F051F0
D1FF51FFD1FE51FED1FD51FDD1FC51FCD1FB51FBD1FA51FAD1F951F9D1F851F8

// File: cacheTop.f
+incdir+test
common/cachePkg.sv
cache/tagStore.sv
cache/lineStore.sv
cache/cacheCtrl.sv
memory/blockMemory.sv
src/cacheTop.sv
test/cacheTb.sv

// File: Bender.yml
package:
  name: cacheTop

sources:
  - common/cachePkg.sv
  - cache/tagStore.sv
  - cache/lineStore.sv
  - cache/cacheCtrl.sv
  - memory/blockMemory.sv
  - src/cacheTop.sv
  - target: test
    include_dirs:
      - test
    files:
      - test/cacheTb.sv
